//--- hw/otp_pkg.sv
/*
  OTP macro interface definitions
  One native fuse word is 16 bits and every transfer moves exactly one word
  Error codes are ordered by the FSM's view of fault severity
*/
package otp_pkg;

  // Native fuse word and word address widths
  parameter int OtpWidth     = 16;
  parameter int OtpAddrWidth = 5;

  // Macro command
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Error codes reported by the macro and the programming FSM
  typedef enum logic [2:0] {
    NoError         = 3'h0,
    MacroWriteError = 3'h1,
    FsmStateError   = 3'h2
  } otp_err_e;

  // Request from the programming FSM to the macro
  typedef struct packed {
    logic                    req;
    otp_cmd_e                cmd;
    logic [OtpAddrWidth-1:0] addr;
    logic [OtpWidth-1:0]     wdata;
  } otp_req_t;

  // Response from the macro, err only meaningful with rvalid
  typedef struct packed {
    logic     gnt;
    logic     rvalid;
    otp_err_e err;
  } otp_rsp_t;

endpackage

//--- hw/lc_pkg.sv
/*
  Life cycle multibit signal definitions
  Only On and Off are legal encodings
  The loose decode treats every value other than Off as asserted
*/
package lc_pkg;

  // Multibit control signal, complementary encodings
  typedef enum logic [3:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lc_tx_e;

  // Loose decode
  // A corrupted encoding fails towards the asserted side
  function automatic logic lc_tx_test_true_loose(lc_tx_e val);
    return val != Off;
  endfunction

endpackage

//--- hw/lc_req_intake.sv
/*
  Request intake for the life cycle programming path
  Escalation is a multibit level and passes through two flops before decode
  A request is taken only while the FSM reports idle and no start is pending
*/
`timescale 1ns/100ps

module lc_req_intake #(
  parameter int NumLcWords = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  lc_pkg::lc_tx_e                          escalate_en_i,
  input  logic                                    lc_req_i,
  input  logic [NumLcWords*otp_pkg::OtpWidth-1:0] lc_data_i,
  input  logic                                    idle_i,
  output logic                                    start_o,
  output logic [NumLcWords*otp_pkg::OtpWidth-1:0] data_o,
  output logic                                    esc_o
);
  import lc_pkg::*;
  import otp_pkg::*;

  lc_tx_e                         esc_meta_q;
  lc_tx_e                         esc_sync_q;
  logic                           accept;
  logic                           start_q;
  logic [NumLcWords*OtpWidth-1:0] data_q;

  ////////////////////////////////////////
  // Escalation synchronizer
  ////////////////////////////////////////

  // Both stages come out of reset deasserted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      esc_meta_q <= Off;
      esc_sync_q <= Off;
    end else begin
      esc_meta_q <= escalate_en_i;
      esc_sync_q <= esc_meta_q;
    end
  end

  assign esc_o = lc_tx_test_true_loose(esc_sync_q);

  ////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////

  // Blocked in the start cycle so a held request level cannot retrigger
  assign accept = lc_req_i && idle_i && !start_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
    end
  end

  // Block stays stable for the whole programming run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= lc_data_i;
    end
  end

  assign start_o = start_q;
  assign data_o  = data_q;

endmodule

//--- hw/otp_lci.sv
/*
  Life cycle programming FSM
  Writes the captured block word by word, one outstanding request at a time
  Macro errors are aggregated and the remaining words are still programmed
  Escalation or a counter fault locks the FSM in its terminal error state
*/
`timescale 1ns/100ps

module otp_lci #(
  parameter int NumLcWords   = 4,
  parameter int LcWordOffset = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    lci_en_i,
  input  logic                                    esc_i,
  input  logic                                    start_i,
  input  logic [NumLcWords*otp_pkg::OtpWidth-1:0] data_i,
  output logic                                    idle_o,
  output logic                                    lc_ack_o,
  output logic                                    lc_err_o,
  output otp_pkg::otp_err_e                       error_o,
  output logic                                    fsm_err_o,
  output otp_pkg::otp_req_t                       otp_req_o,
  input  otp_pkg::otp_rsp_t                       otp_rsp_i
);
  import otp_pkg::*;

  localparam int CntWidth = (NumLcWords > 1) ? $clog2(NumLcWords) : 1;
  localparam logic [CntWidth-1:0] LastWord = CntWidth'(NumLcWords - 1);

  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    WriteSt,
    WriteWaitSt,
    ErrorSt
  } state_e;

  state_e                              state_d, state_q;
  otp_err_e                            error_d, error_q;
  logic                                cnt_clr, cnt_en, cnt_err;
  logic [CntWidth-1:0]                 cnt_up_q, cnt_dn_q, cnt_sum;
  logic [NumLcWords-1:0][OtpWidth-1:0] words;
  logic                                wr_req;

  assign error_o = error_q;
  assign words   = data_i;

  ////////////////////////////////////////
  // Programming FSM
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    error_d   = error_q;
    cnt_clr   = 1'b0;
    cnt_en    = 1'b0;
    wr_req    = 1'b0;
    idle_o    = 1'b0;
    lc_ack_o  = 1'b0;
    lc_err_o  = 1'b0;
    fsm_err_o = 1'b0;

    unique case (state_q)
      // Hold off until the interface is enabled
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Only state that reports idle and takes a start
      IdleSt: begin
        idle_o = 1'b1;
        if (start_i) begin
          cnt_clr = 1'b1;
          state_d = WriteSt;
        end
      end
      // Request stays up until the macro grants
      WriteSt: begin
        wr_req = 1'b1;
        if (otp_rsp_i.gnt) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response, keep the latest non-zero code
      WriteWaitSt: begin
        if (otp_rsp_i.rvalid) begin
          if (otp_rsp_i.err != NoError) begin
            error_d = otp_rsp_i.err;
          end
          if (cnt_up_q == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failed word ends in lockdown
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal, never left without a reset
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched state register
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation and counter faults override everything above
    if (esc_i || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////
  // Redundant word counter
  ////////////////////////////////////////

  // Up and down copies always sum to the last index
  assign cnt_sum = cnt_up_q + cnt_dn_q;
  assign cnt_err = cnt_sum != LastWord;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_up_q <= '0;
      cnt_dn_q <= LastWord;
    end else if (cnt_clr) begin
      cnt_up_q <= '0;
      cnt_dn_q <= LastWord;
    end else if (cnt_en) begin
      cnt_up_q <= cnt_up_q + 1'b1;
      cnt_dn_q <= cnt_dn_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Macro request
  ////////////////////////////////////////

  always_comb begin
    otp_req_o.req   = wr_req;
    otp_req_o.cmd   = Read;
    // Block sits at a fixed word offset in the array
    otp_req_o.addr  = OtpAddrWidth'(LcWordOffset) + OtpAddrWidth'(cnt_up_q);
    otp_req_o.wdata = '0;
    if (wr_req) begin
      otp_req_o.cmd   = Write;
      otp_req_o.wdata = words[cnt_up_q];
    end
  end

  ////////////////////////////////////////
  // State and error registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule

//--- hw/otp_macro.sv
/*
  Behavioral OTP fuse array
  Reset models a blank part with every fuse at zero
  Writes only ever set bits, a requested clear is refused and flagged
  One request in flight, its response comes two cycles after the grant
*/
`timescale 1ns/100ps

module otp_macro #(
  parameter int NumOtpWords = 16
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  otp_pkg::otp_req_t                 otp_req_i,
  output otp_pkg::otp_rsp_t                 otp_rsp_o,
  input  logic [otp_pkg::OtpAddrWidth-1:0]  rd_addr_i,
  output logic [otp_pkg::OtpWidth-1:0]      rd_data_o
);
  import otp_pkg::*;

  localparam int IdxWidth = (NumOtpWords > 1) ? $clog2(NumOtpWords) : 1;

  logic [OtpWidth-1:0] mem_q [NumOtpWords];
  logic                gnt, wr_en, in_range, rd_in_range, clr_viol;
  logic [IdxWidth-1:0] wr_idx, rd_idx;
  logic [OtpWidth-1:0] stored;
  logic                v1_q, v2_q;
  otp_err_e            err_d, err1_q, err2_q;
  logic [OtpWidth-1:0] rd_data_q;

  ////////////////////////////////////////
  // Grant and write check
  ////////////////////////////////////////

  // No new grant while a response is still in the pipeline
  assign gnt   = otp_req_i.req && !(v1_q || v2_q);
  assign wr_en = gnt && (otp_req_i.cmd == Write);

  assign in_range = int'(otp_req_i.addr) < NumOtpWords;
  assign wr_idx   = otp_req_i.addr[IdxWidth-1:0];
  assign stored   = in_range ? mem_q[wr_idx] : '0;

  // Stored one where the new data has a zero
  assign clr_viol = |(stored & ~otp_req_i.wdata);
  assign err_d    = (wr_en && clr_viol) ? MacroWriteError : NoError;

  // OR-in so that programmed fuses survive a bad write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumOtpWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en && in_range) begin
      mem_q[wr_idx] <= stored | otp_req_i.wdata;
    end
  end

  ////////////////////////////////////////
  // Response pipeline
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v1_q   <= 1'b0;
      v2_q   <= 1'b0;
      err1_q <= NoError;
      err2_q <= NoError;
    end else begin
      v1_q   <= gnt;
      v2_q   <= v1_q;
      err1_q <= err_d;
      err2_q <= err1_q;
    end
  end

  assign otp_rsp_o.gnt    = gnt;
  assign otp_rsp_o.rvalid = v2_q;
  assign otp_rsp_o.err    = v2_q ? err2_q : NoError;

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  assign rd_in_range = int'(rd_addr_i) < NumOtpWords;
  assign rd_idx      = rd_addr_i[IdxWidth-1:0];

  // Unmapped addresses read as blank
  always_ff @(posedge clk_i) begin
    rd_data_q <= rd_in_range ? mem_q[rd_idx] : '0;
  end

  assign rd_data_o = rd_data_q;

endmodule

//--- hw/lc_otp_prog_top.sv
/*
  Life cycle OTP programming subsystem
  Block size, block offset and array depth are set here and passed down
  The block must fit inside the array at the given word offset
*/
`timescale 1ns/100ps

module lc_otp_prog_top #(
  parameter int NumLcWords   = 4,
  parameter int LcWordOffset = 4,
  parameter int NumOtpWords  = 16
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    lci_en_i,
  input  lc_pkg::lc_tx_e                          escalate_en_i,
  input  logic                                    lc_req_i,
  input  logic [NumLcWords*otp_pkg::OtpWidth-1:0] lc_data_i,
  input  logic [otp_pkg::OtpAddrWidth-1:0]        rd_addr_i,
  output logic                                    lc_ack_o,
  output logic                                    lc_err_o,
  output otp_pkg::otp_err_e                       error_o,
  output logic                                    fsm_err_o,
  output logic                                    lci_idle_o,
  output logic [otp_pkg::OtpWidth-1:0]            rd_data_o
);
  import otp_pkg::*;

  // Intake to FSM
  logic                           start;
  logic                           esc;
  logic [NumLcWords*OtpWidth-1:0] data;

  // FSM to macro
  otp_req_t otp_req;
  otp_rsp_t otp_rsp;

  lc_req_intake #(
    .NumLcWords(NumLcWords)
  ) lc_req_intake_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .escalate_en_i(escalate_en_i),
    .lc_req_i     (lc_req_i),
    .lc_data_i    (lc_data_i),
    .idle_i       (lci_idle_o),
    .start_o      (start),
    .data_o       (data),
    .esc_o        (esc)
  );

  otp_lci #(
    .NumLcWords  (NumLcWords),
    .LcWordOffset(LcWordOffset)
  ) otp_lci_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .lci_en_i (lci_en_i),
    .esc_i    (esc),
    .start_i  (start),
    .data_i   (data),
    .idle_o   (lci_idle_o),
    .lc_ack_o (lc_ack_o),
    .lc_err_o (lc_err_o),
    .error_o  (error_o),
    .fsm_err_o(fsm_err_o),
    .otp_req_o(otp_req),
    .otp_rsp_i(otp_rsp)
  );

  otp_macro #(
    .NumOtpWords(NumOtpWords)
  ) otp_macro_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .otp_req_i(otp_req),
    .otp_rsp_o(otp_rsp),
    .rd_addr_i(rd_addr_i),
    .rd_data_o(rd_data_o)
  );

endmodule

//--- dv/lc_otp_prog_checker.sv
/*
  Protocol assertions for the programming subsystem, bound to its top level
  Covers the FSM to macro handshake and the completion strobes only
*/
`timescale 1ns/100ps

module lc_otp_prog_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              lc_ack_i,
  input logic              lc_err_i,
  input otp_pkg::otp_req_t otp_req_i,
  input otp_pkg::otp_rsp_t otp_rsp_i
);

  // Error strobe only comes with the ack
  err_with_ack_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lc_err_i |-> lc_ack_i
  ) else $error("lc_err_o raised without lc_ack_o");

  // Request and its payload hold until granted
  req_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    otp_req_i.req && !otp_rsp_i.gnt |=>
      otp_req_i.req && $stable(otp_req_i.addr) && $stable(otp_req_i.wdata)
  ) else $error("macro request dropped or changed before grant");

  // Fixed two cycle response latency in both directions
  gnt_to_rvalid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) otp_rsp_i.gnt |-> ##2 otp_rsp_i.rvalid
  ) else $error("no rvalid two cycles after grant");

  rvalid_from_gnt_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) otp_rsp_i.rvalid |-> $past(otp_rsp_i.gnt, 2)
  ) else $error("rvalid without a grant two cycles earlier");

  // Ack stays low while reset is held
  no_ack_in_reset_a: assert property (
    @(posedge clk_i) !rst_ni |-> !lc_ack_i
  ) else $error("lc_ack_o high during reset");

endmodule

bind lc_otp_prog_top lc_otp_prog_checker lc_otp_prog_checker_inst (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .lc_ack_i (lc_ack_o),
  .lc_err_i (lc_err_o),
  .otp_req_i(otp_req),
  .otp_rsp_i(otp_rsp)
);

//--- dv/tb_lc_otp_prog.sv
/*
  Directed testbench for the life cycle OTP programming subsystem
  Expected fuse contents come from a model array kept by the OR rule
  Escalation runs last, after a fresh reset that blanks the array
*/
`timescale 1ns/100ps

module tb_lc_otp_prog;
  import otp_pkg::*;
  import lc_pkg::*;

  localparam int NumLcWords    = 4;
  localparam int LcWordOffset  = 4;
  localparam int NumOtpWords   = 16;
  // Five tests of at most 200 cycles each
  localparam int TimeoutCycles = 5 * 200;

  logic                           clk, rst_n, lci_en, lc_req;
  lc_tx_e                         escalate_en;
  logic [NumLcWords*OtpWidth-1:0] lc_data;
  logic [OtpAddrWidth-1:0]        rd_addr;
  logic                           lc_ack, lc_err, fsm_err, lci_idle;
  otp_err_e                       error;
  logic [OtpWidth-1:0]            rd_data;

  logic [OtpWidth-1:0] model_mem [NumOtpWords];
  logic [15:0]         lfsr;
  int                  cycle_cnt, check_cnt, err_cnt;

  lc_otp_prog_top #(
    .NumLcWords  (NumLcWords),
    .LcWordOffset(LcWordOffset),
    .NumOtpWords (NumOtpWords)
  ) lc_otp_prog_top_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .lci_en_i     (lci_en),
    .escalate_en_i(escalate_en),
    .lc_req_i     (lc_req),
    .lc_data_i    (lc_data),
    .rd_addr_i    (rd_addr),
    .lc_ack_o     (lc_ack),
    .lc_err_o     (lc_err),
    .error_o      (error),
    .fsm_err_o    (fsm_err),
    .lci_idle_o   (lci_idle),
    .rd_data_o    (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checks and helpers
  ////////////////////////////////////////

  task automatic check_word(string name, logic [OtpWidth-1:0] got, logic [OtpWidth-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_err(string name, otp_err_e got, otp_err_e exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(string msg);
    err_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // 16-bit Galois LFSR stepped once per bit taken
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_block(output logic [NumLcWords*OtpWidth-1:0] block);
    for (int i = 0; i < NumLcWords * OtpWidth; i++) begin
      lfsr     = lfsr_next(lfsr);
      block[i] = lfsr[0];
    end
  endtask

  // Drive point sits 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Outputs are sampled on the falling edge away from the drive point
  task automatic wait_flag(input string name, input int limit, output bit seen);
    logic level;
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clk);
      case (name)
        "ack":   level = lc_ack;
        "idle":  level = lci_idle;
        default: level = fsm_err;
      endcase
      seen = (level === 1'b1);
    end
  endtask

  task automatic apply_reset();
    rst_n       = 1'b0;
    lci_en      = 1'b0;
    lc_req      = 1'b0;
    escalate_en = Off;
    lc_data     = '0;
    rd_addr     = '0;
    // Blank part after reset
    for (int i = 0; i < NumOtpWords; i++) begin
      model_mem[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic enable_lci();
    bit seen;
    next_cycle();
    lci_en = 1'b1;
    wait_flag("idle", 20, seen);
    if (!seen) begin
      report_failure("lci_idle_o did not rise after lci_en_i");
    end
  endtask

  task automatic send_request(logic [NumLcWords*OtpWidth-1:0] block);
    next_cycle();
    lc_data = block;
    lc_req  = 1'b1;
    next_cycle();
    lc_req = 1'b0;
  endtask

  // Read data is registered and lags the address by one cycle
  task automatic read_word(input int addr, output logic [OtpWidth-1:0] data);
    next_cycle();
    rd_addr = OtpAddrWidth'(addr);
    @(posedge clk);
    @(negedge clk);
    data = rd_data;
  endtask

  // Full programming run checked against the OR rule
  task automatic program_block(logic [NumLcWords*OtpWidth-1:0] block);
    bit                  seen, exp_err;
    logic [OtpWidth-1:0] word, got;
    exp_err = 1'b0;
    for (int i = 0; i < NumLcWords; i++) begin
      word = block[i*OtpWidth +: OtpWidth];
      // A programmed bit with a zero in the new word is a clear attempt
      if ((model_mem[LcWordOffset+i] & ~word) != '0) begin
        exp_err = 1'b1;
      end
      model_mem[LcWordOffset+i] |= word;
    end
    send_request(block);
    wait_flag("ack", 50, seen);
    if (!seen) begin
      report_failure("no lc_ack_o for a programming request");
    end else begin
      check_flag("lc_err_o", lc_err, exp_err);
    end
    for (int i = 0; i < NumLcWords; i++) begin
      read_word(LcWordOffset + i, got);
      check_word($sformatf("fuse word %0d", LcWordOffset + i), got, model_mem[LcWordOffset+i]);
    end
  endtask

  task automatic expect_no_ack();
    bit seen;
    send_request('1);
    wait_flag("ack", 100, seen);
    if (seen) begin
      report_failure("request was acknowledged after lockdown");
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_after_reset();
    @(negedge clk);
    check_flag("lci_idle_o", lci_idle, 1'b0);
    check_flag("lc_ack_o", lc_ack, 1'b0);
    check_flag("lc_err_o", lc_err, 1'b0);
    check_err("error_o", error, NoError);
    enable_lci();
  endtask

  task automatic test_fresh_program();
    logic [NumLcWords*OtpWidth-1:0] block;
    rand_block(block);
    program_block(block);
  endtask

  task automatic test_superset_program();
    logic [NumLcWords*OtpWidth-1:0] block;
    rand_block(block);
    // Keep every fuse already blown
    for (int i = 0; i < NumLcWords; i++) begin
      block[i*OtpWidth +: OtpWidth] |= model_mem[LcWordOffset+i];
    end
    program_block(block);
  endtask

  task automatic test_clearing_program();
    logic [NumLcWords*OtpWidth-1:0] block;
    rand_block(block);
    if (model_mem[LcWordOffset] == '0) begin
      report_failure("first block word has no programmed bit to clear");
    end
    // First word drops all of its programmed bits
    block[OtpWidth-1:0] = block[OtpWidth-1:0] & ~model_mem[LcWordOffset];
    program_block(block);
    check_err("error_o", error, MacroWriteError);
    check_flag("lci_idle_o", lci_idle, 1'b0);
    expect_no_ack();
  endtask

  task automatic test_escalation();
    bit seen;
    next_cycle();
    apply_reset();
    enable_lci();
    next_cycle();
    escalate_en = On;
    wait_flag("fsm_err", 20, seen);
    if (!seen) begin
      report_failure("fsm_err_o did not rise on escalation");
    end
    // Error code lands one edge after the fault shows
    @(negedge clk);
    check_flag("fsm_err_o", fsm_err, 1'b1);
    check_err("error_o", error, FsmStateError);
    check_flag("lci_idle_o", lci_idle, 1'b0);
    expect_no_ack();
  endtask

  initial begin
    check_cnt = 0;
    err_cnt   = 0;
    lfsr      = 16'd36;
    apply_reset();
    test_after_reset();
    test_fresh_program();
    test_superset_program();
    test_clearing_program();
    test_escalation();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- lc_otp_prog.f
hw/otp_pkg.sv
hw/lc_pkg.sv
hw/lc_req_intake.sv
hw/otp_lci.sv
hw/otp_macro.sv
hw/lc_otp_prog_top.sv
dv/lc_otp_prog_checker.sv
dv/tb_lc_otp_prog.sv

//--- Makefile
# Verilator run of the life cycle OTP programming testbench
TOP := tb_lc_otp_prog

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f lc_otp_prog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
